// ==== hps_pkg.sv ====
/*
 command codes, bus widths and event types shared by the host bridge
 only the user-I/O and file-download command subsets are decoded
*/
`default_nettype none

package hps_pkg;

	////////////////////
	// bus words

	// one 16-bit word on the host bus
	typedef logic [15:0] word_t;

	// index of a word inside a command frame, saturates at all ones
	typedef logic [8:0] cnt_t;

	// width of the core download address
	localparam int DL_ADDR_W = 27;

	////////////////////
	// user-I/O commands

	localparam logic [7:0] CMD_CFG        = 8'h01;
	localparam logic [7:0] CMD_JOY0       = 8'h02;
	localparam logic [7:0] CMD_JOY1       = 8'h03;
	localparam logic [7:0] CMD_KBD        = 8'h05;
	localparam logic [7:0] CMD_RAWJOY     = 8'h0f;
	localparam logic [7:0] CMD_JOY2       = 8'h10;
	localparam logic [7:0] CMD_JOY3       = 8'h11;
	localparam logic [7:0] CMD_CONFSTR    = 8'h14;
	localparam logic [7:0] CMD_STATUS     = 8'h1e;
	localparam logic [7:0] CMD_STATUS_REQ = 8'h29;
	localparam logic [7:0] CMD_MENUMASK   = 8'h2e;

	// upper nibble of the first reply to a status request
	localparam logic [3:0] STATUS_REQ_TAG = 4'ha;

	////////////////////
	// file-transfer commands

	localparam logic [7:0] FIO_FILE_TX     = 8'h53;
	localparam logic [7:0] FIO_FILE_TX_DAT = 8'h54;
	localparam logic [7:0] FIO_FILE_INDEX  = 8'h55;
	localparam logic [7:0] FIO_FILE_INFO   = 8'h56;

	////////////////////
	// keyboard event

	// toggle flips on every reported key event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_t;

endpackage

`default_nettype wire

// ==== hps_cmd_if.sv ====
/*
 decoded user-I/O command frame, driven by the framer
 strobe is combinational with the host strobe, no back-pressure
*/
`timescale 1ns/1ps
`default_nettype none

interface hps_cmd_if import hps_pkg::*; ();

	// one cycle per host word inside a frame
	logic  strobe;
	// index of the current word, 0 is the command itself
	cnt_t  cnt;
	// latched command, valid from word 1 on
	word_t cmd;
	// host word of the current strobe
	word_t din;
	// one cycle pulse after the frame closes
	logic  frame_end;

	modport framer (
		output strobe,
		output cnt,
		output cmd,
		output din,
		output frame_end
	);

	modport sink (
		input strobe,
		input cnt,
		input cmd,
		input din,
		input frame_end
	);

endinterface

`default_nettype wire

// ==== hps_cmd_frame.sv ====
/*
 framing of the io_enable command bus
 the host must keep io_enable high for the whole frame
*/
`timescale 1ns/1ps
`default_nettype none

module hps_cmd_frame import hps_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      io_enable,
	input  logic      io_strobe,
	input  word_t     io_din,
	hps_cmd_if.framer cmd_if
);

	logic  enable_q;
	logic  frame_end_q;
	logic  word_stb;
	cnt_t  word_cnt;
	word_t cmd_q;

	assign word_stb = io_enable & io_strobe;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			enable_q    <= 1'b0;
			frame_end_q <= 1'b0;
			word_cnt    <= '0;
			cmd_q       <= '0;
		end else begin
			enable_q    <= io_enable;
			// falling edge of the frame enable, seen one cycle late
			frame_end_q <= enable_q & ~io_enable;

			if (!io_enable) begin
				word_cnt <= '0;
			end else if (word_stb && !(&word_cnt)) begin
				word_cnt <= word_cnt + 1'b1;
			end

			// command survives the frame_end cycle, then clears
			if (frame_end_q) begin
				cmd_q <= '0;
			end
			if (word_stb && word_cnt == '0) begin
				cmd_q <= io_din;
			end
		end
	end

	assign cmd_if.strobe    = word_stb;
	assign cmd_if.cnt       = word_cnt;
	assign cmd_if.cmd       = cmd_q;
	assign cmd_if.din       = io_din;
	assign cmd_if.frame_end = frame_end_q;

endmodule

`default_nettype wire

// ==== hps_user_regs.sv ====
/*
 user registers written by the host and the registered reply word
 conf_str must be exactly STRLEN bytes, first character in the top byte
*/
`timescale 1ns/1ps
`default_nettype none

module hps_user_regs import hps_pkg::*; #(
	parameter int STRLEN = 1
) (
	input  logic              clk_sys,
	input  logic              rst_n,
	hps_cmd_if.sink           cmd_if,
	input  logic [8*STRLEN-1:0] conf_str,
	input  logic [5:0]        raw_joy,
	input  logic [63:0]       status_in,
	input  logic              status_set,
	input  word_t             status_menumask,
	output word_t             io_dout,
	output logic [31:0]       joystick_0,
	output logic [31:0]       joystick_1,
	output logic [31:0]       joystick_2,
	output logic [31:0]       joystick_3,
	output logic [63:0]       status,
	output logic [1:0]        buttons,
	output logic              forced_scandoubler,
	output logic              direct_video
);

	word_t       cfg;
	logic [31:0] joy [4];
	logic [1:0]  joy_sel;
	logic        joy_cmd;
	logic        status_set_q;
	logic [3:0]  stflg;
	logic [63:0] status_req;

	// joystick commands are not contiguous
	always_comb begin
		joy_sel = 2'd0;
		joy_cmd = 1'b1;
		case (cmd_if.cmd)
			CMD_JOY0: joy_sel = 2'd0;
			CMD_JOY1: joy_sel = 2'd1;
			CMD_JOY2: joy_sel = 2'd2;
			CMD_JOY3: joy_sel = 2'd3;
			default:  joy_cmd = 1'b0;
		endcase
	end

	////////////////////
	// host writes

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cfg    <= '0;
			joy    <= '{default: '0};
			status <= '0;
		end else if (cmd_if.strobe && cmd_if.cnt != '0) begin
			if (cmd_if.cmd == CMD_CFG && cmd_if.cnt == cnt_t'(1)) begin
				cfg <= cmd_if.din;
			end

			// first word is the low half, any later word the high half
			if (joy_cmd) begin
				if (cmd_if.cnt == cnt_t'(1)) begin
					joy[joy_sel][15:0] <= cmd_if.din;
				end else begin
					joy[joy_sel][31:16] <= cmd_if.din;
				end
			end

			if (cmd_if.cmd == CMD_STATUS && cmd_if.cnt <= cnt_t'(4)) begin
				status[16*(int'(cmd_if.cnt) - 1) +: 16] <= cmd_if.din;
			end
		end
	end

	////////////////////
	// core status request

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status_set_q <= 1'b0;
			stflg        <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				stflg <= stflg + 1'b1;
			end
		end
	end

	// requested value is captured on the same edge as the count
	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_q) begin
			status_req <= status_in;
		end
	end

	////////////////////
	// reply word

	// zero unless the word just strobed asks for data
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			io_dout <= '0;
		end else begin
			io_dout <= '0;
			if (cmd_if.strobe) begin
				if (cmd_if.cnt == '0) begin
					if (cmd_if.din == word_t'(CMD_STATUS_REQ)) begin
						io_dout <= {8'h00, STATUS_REQ_TAG, stflg};
					end
				end else begin
					case (cmd_if.cmd)
						CMD_STATUS_REQ: begin
							if (cmd_if.cnt <= cnt_t'(4)) begin
								io_dout <= status_req[16*(int'(cmd_if.cnt) - 1) +: 16];
							end
						end
						CMD_MENUMASK: begin
							if (cmd_if.cnt == cnt_t'(1)) begin
								io_dout <= status_menumask;
							end
						end
						CMD_RAWJOY: io_dout <= {10'd0, raw_joy};
						// byte k-1 of the string, counted from the top
						CMD_CONFSTR: begin
							if (cmd_if.cnt <= STRLEN) begin
								io_dout <= {8'h00, conf_str[8*(STRLEN - int'(cmd_if.cnt)) +: 8]};
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];

	// remaining config bits are used outside the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

endmodule

`default_nettype wire

// ==== hps_ps2_key.sv ====
/*
 PS/2 scan-code assembly from keyboard command frames
 only the last four bytes of a frame are kept
*/
`timescale 1ns/1ps
`default_nettype none

module hps_ps2_key import hps_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	hps_cmd_if.sink    cmd_if,
	output key_event_t ps2_key
);

	logic [31:0] key_raw;
	logic        skip;
	logic        pressed;
	logic        extended;
	logic        kbd_word;

	assign kbd_word = cmd_if.strobe && cmd_if.cnt != '0 && cmd_if.cmd == CMD_KBD;

	// on a release the prefix sits in front of the F0 byte
	assign pressed  = key_raw[15:8] != 8'hf0;
	assign extended = pressed ? (key_raw[15:8] == 8'he0) : (key_raw[23:16] == 8'he0);

	// byte history, newest byte at the bottom
	always_ff @(posedge clk_sys) begin
		if (cmd_if.strobe && cmd_if.cnt == '0 && cmd_if.din == word_t'(CMD_KBD)) begin
			key_raw <= '0;
		end else if (kbd_word && !(&cmd_if.din[15:8]) && !skip) begin
			key_raw <= {key_raw[23:0], cmd_if.din[7:0]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (cmd_if.strobe && cmd_if.cnt == '0) begin
				skip <= 1'b0;
			end else if (kbd_word && (&cmd_if.din[15:8])) begin
				skip <= 1'b1;
			end

			if (cmd_if.frame_end && cmd_if.cmd == CMD_KBD && !skip) begin
				ps2_key.toggle <= ~ps2_key.toggle;
				case (key_raw)
					// print screen make
					32'he012e07c: {ps2_key.pressed, ps2_key.extended, ps2_key.code} <= 10'h37c;
					// print screen break
					32'h7ce0f012: {ps2_key.pressed, ps2_key.extended, ps2_key.code} <= 10'h17c;
					// pause has no break code
					32'hf014f077: {ps2_key.pressed, ps2_key.extended, ps2_key.code} <= 10'h377;
					default: begin
						ps2_key.pressed  <= pressed;
						ps2_key.extended <= extended;
						ps2_key.code     <= key_raw[7:0];
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hps_file_rx.sv ====
/*
 file download from the host into the core, 8-bit data only
 no wait input, the core must accept one byte per ioctl_wr
*/
`timescale 1ns/1ps
`default_nettype none

module hps_file_rx import hps_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 fp_enable,
	input  logic                 io_strobe,
	input  word_t                io_din,
	output word_t                fp_dout,
	output logic                 ioctl_download,
	output word_t                ioctl_index,
	output logic                 ioctl_wr,
	output logic [DL_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]           ioctl_dout,
	output logic [31:0]          ioctl_file_ext
);

	logic                 has_cmd;
	word_t                cmd;
	logic [1:0]           arg_cnt;
	logic [DL_ADDR_W-1:0] addr;
	logic                 wr;

	// nothing is ever read back over the file bus
	assign fp_dout = '0;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			has_cmd        <= 1'b0;
			cmd            <= '0;
			arg_cnt        <= '0;
			addr           <= '0;
			wr             <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_file_ext <= '0;
		end else begin
			// write strobe trails the data by one cycle
			ioctl_wr <= wr;
			wr       <= 1'b0;

			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd     <= io_din;
					has_cmd <= 1'b1;
					arg_cnt <= '0;
				end else begin
					if (!(&arg_cnt)) begin
						arg_cnt <= arg_cnt + 1'b1;
					end

					case (cmd)
						// extension, upper half first
						FIO_FILE_INFO: begin
							if (arg_cnt == 2'd0) begin
								ioctl_file_ext[31:16] <= io_din;
							end else if (arg_cnt == 2'd1) begin
								ioctl_file_ext[15:0] <= io_din;
							end
						end

						FIO_FILE_INDEX: ioctl_index <= io_din;

						FIO_FILE_TX: begin
							case (arg_cnt)
								2'd0: begin
									if (io_din != '0) begin
										addr           <= '0;
										ioctl_download <= 1'b1;
									end else begin
										// leave the final address visible
										if (ioctl_download) begin
											ioctl_addr <= addr;
										end
										ioctl_download <= 1'b0;
									end
								end
								2'd1: begin
									ioctl_addr[15:0] <= io_din;
									addr[15:0]       <= io_din;
								end
								2'd2: begin
									ioctl_addr[26:16] <= io_din[10:0];
									addr[26:16]       <= io_din[10:0];
								end
								default: ;
							endcase
						end

						FIO_FILE_TX_DAT: begin
							if (ioctl_download) begin
								ioctl_addr <= addr;
								ioctl_dout <= io_din[7:0];
								wr         <= 1'b1;
								addr       <= addr + 1'b1;
							end
						end

						default: ;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hps_io.sv ====
/*
 host-to-core command bridge, top level with plain host bus ports
 STRLEN must equal the byte length of conf_str
*/
`timescale 1ns/1ps
`default_nettype none

module hps_io import hps_pkg::*; #(
	parameter int STRLEN = 1
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,

	// host bus
	input  logic                 io_enable,
	input  logic                 fp_enable,
	input  logic                 io_strobe,
	input  word_t                io_din,
	output word_t                io_dout,
	output word_t                fp_dout,

	// core side
	input  logic [8*STRLEN-1:0]  conf_str,
	input  logic [5:0]           raw_joy,
	input  logic [63:0]          status_in,
	input  logic                 status_set,
	input  word_t                status_menumask,
	output logic [31:0]          joystick_0,
	output logic [31:0]          joystick_1,
	output logic [31:0]          joystick_2,
	output logic [31:0]          joystick_3,
	output logic [63:0]          status,
	output logic [1:0]           buttons,
	output logic                 forced_scandoubler,
	output logic                 direct_video,
	output key_event_t           ps2_key,

	// download port
	output logic                 ioctl_download,
	output word_t                ioctl_index,
	output logic                 ioctl_wr,
	output logic [DL_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]           ioctl_dout,
	output logic [31:0]          ioctl_file_ext
);

	hps_cmd_if cmd_if ();

	////////////////////
	// user-I/O path

	hps_cmd_frame u_frame (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.cmd_if    (cmd_if.framer)
	);

	hps_user_regs #(
		.STRLEN (STRLEN)
	) u_regs (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.cmd_if             (cmd_if.sink),
		.conf_str           (conf_str),
		.raw_joy            (raw_joy),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.io_dout            (io_dout),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.status             (status),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video)
	);

	hps_ps2_key u_key (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.cmd_if  (cmd_if.sink),
		.ps2_key (ps2_key)
	);

	////////////////////
	// file path, framed by fp_enable

	hps_file_rx u_file (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.fp_enable      (fp_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.fp_dout        (fp_dout),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

endmodule

`default_nettype wire

// ==== hps_io_assert.sv ====
/*
 protocol checks on the bridge outputs, bound into every hps_io instance
 all properties are disabled while rst_n is low
*/
`timescale 1ns/1ps
`default_nettype none

module hps_io_assert import hps_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst_n,
	input  logic  io_enable,
	input  word_t io_dout,
	input  logic  ioctl_wr,
	input  logic  ioctl_download
);

	// one write pulse per downloaded byte
	wr_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |=> !ioctl_wr)
		else $error("ioctl_wr held high for two cycles");

	wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download)
		else $error("ioctl_wr outside of a download");

	// reply register only loads on strobes inside a frame
	dout_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$past(io_enable) |-> io_dout == '0)
		else $error("io_dout nonzero after a cycle without io_enable");

endmodule

bind hps_io hps_io_assert u_assert (
	.clk_sys        (clk_sys),
	.rst_n          (rst_n),
	.io_enable      (io_enable),
	.io_dout        (io_dout),
	.ioctl_wr       (ioctl_wr),
	.ioctl_download (ioctl_download)
);

`default_nettype wire

// ==== tb_hps_io.sv ====
/*
 random host traffic against the bridge, checked against a model
 inputs change on the falling edge and outputs are sampled there too
*/
`timescale 1ns/1ps
`default_nettype none

module tb_hps_io;
	import hps_pkg::*;

	localparam int STRLEN        = 6;
	localparam int RESET_CYCLES  = 16;
	localparam int ROUNDS_CFG    = 4;
	localparam int ROUNDS_STATUS = 3;
	localparam int KEY_ITER      = 24;
	localparam int DL_BYTES      = 20;

	// worst case per word is gap 4, strobe 1 and one spare cycle
	localparam int WORD_CYC    = 6;
	localparam int FRAME_CYC   = 5;
	localparam int PLAN_WORDS  = ROUNDS_CFG * 14 + ROUNDS_STATUS * 14 + (STRLEN + 3)
		+ KEY_ITER * 4 + 20 + DL_BYTES + 16;
	localparam int PLAN_FRAMES = ROUNDS_CFG * 5 + ROUNDS_STATUS * 4 + 1 + KEY_ITER + 4 + 6;
	localparam int PLAN_CYCLES = RESET_CYCLES + PLAN_WORDS * WORD_CYC
		+ PLAN_FRAMES * FRAME_CYC + ROUNDS_STATUS * 10;
	localparam int TIMEOUT_CYCLES = 4 * PLAN_CYCLES;

	logic                 clk_sys;
	logic                 rst_n;
	logic                 io_enable;
	logic                 fp_enable;
	logic                 io_strobe;
	word_t                io_din;
	word_t                io_dout;
	word_t                fp_dout;
	logic [8*STRLEN-1:0]  conf_str;
	logic [5:0]           raw_joy;
	logic [63:0]          status_in;
	logic                 status_set;
	word_t                status_menumask;
	logic [31:0]          joystick_0;
	logic [31:0]          joystick_1;
	logic [31:0]          joystick_2;
	logic [31:0]          joystick_3;
	logic [63:0]          status;
	logic [1:0]           buttons;
	logic                 forced_scandoubler;
	logic                 direct_video;
	key_event_t           ps2_key;
	logic                 ioctl_download;
	word_t                ioctl_index;
	logic                 ioctl_wr;
	logic [DL_ADDR_W-1:0] ioctl_addr;
	logic [7:0]           ioctl_dout;
	logic [31:0]          ioctl_file_ext;

	integer seed;
	int     cycle_count;
	string  conf_text;

	// frame words to send and the io_dout seen after each strobe
	word_t tx_words[$];
	word_t rx_words[$];

	// reference model
	word_t                m_cfg;
	logic [31:0]          m_joy[4];
	logic [63:0]          m_status;
	logic [3:0]           m_stflg;
	logic [63:0]          m_req;
	key_event_t           m_key;
	logic [DL_ADDR_W-1:0] dl_addr_q[$];
	logic [7:0]           dl_data_q[$];

	hps_io #(
		.STRLEN (STRLEN)
	) DUT (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.fp_dout            (fp_dout),
		.conf_str           (conf_str),
		.raw_joy            (raw_joy),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.status             (status),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_file_ext     (ioctl_file_ext)
	);

	initial begin
		clk_sys = 1'b0;
	end

	always #50 clk_sys = ~clk_sys;

	////////////////////
	// checking

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_word(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %0d ns: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_key(input key_event_t actual, input key_event_t expected,
		input string what);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %0d ns: %s key event is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_dl(input logic [DL_ADDR_W-1:0] addr, input logic [7:0] data,
		input logic [DL_ADDR_W-1:0] exp_addr, input logic [7:0] exp_data);
		if (addr !== exp_addr || data !== exp_data) begin
			abort_run($sformatf("FAILED at %0d ns: download write %h @ %h, expected %h @ %h",
				$time, data, addr, exp_data, exp_addr));
		end
	endtask

	// every write pulse must match the next queued byte
	always @(negedge clk_sys) begin
		if (rst_n && ioctl_wr) begin
			if (dl_addr_q.size() == 0) begin
				abort_run($sformatf("ioctl_wr pulsed at %0d ns with no byte pending", $time));
			end else begin
				check_dl(ioctl_addr, ioctl_dout, dl_addr_q[0], dl_data_q[0]);
				void'(dl_addr_q.pop_front());
				void'(dl_data_q.pop_front());
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	////////////////////
	// host bus

	task automatic start_cmd(input logic [7:0] code);
		tx_words.delete();
		tx_words.push_back({8'h00, code});
	endtask

	task automatic add_word(input word_t w);
		tx_words.push_back(w);
	endtask

	// one strobe per word with random idle gaps of at least min_gap cycles
	task automatic send_frame(input logic file_bus, input int min_gap);
		int gap;
		int i;
		rx_words.delete();
		@(negedge clk_sys);
		if (file_bus) begin
			fp_enable = 1'b1;
		end else begin
			io_enable = 1'b1;
		end
		for (i = 0; i < tx_words.size(); i++) begin
			gap = min_gap + ($random(seed) & 3);
			repeat (gap) @(negedge clk_sys);
			io_din    = tx_words[i];
			io_strobe = 1'b1;
			@(negedge clk_sys);
			io_strobe = 1'b0;
			rx_words.push_back(io_dout);
		end
		io_enable = 1'b0;
		fp_enable = 1'b0;
		// frame end and the key event need two more cycles
		repeat (3) @(negedge clk_sys);
	endtask

	function automatic logic [7:0] joy_code(input int j);
		case (j)
			0:       return CMD_JOY0;
			1:       return CMD_JOY1;
			2:       return CMD_JOY2;
			default: return CMD_JOY3;
		endcase
	endfunction

	function automatic logic [31:0] joy_out(input int j);
		case (j)
			0:       return joystick_0;
			1:       return joystick_1;
			2:       return joystick_2;
			default: return joystick_3;
		endcase
	endfunction

	////////////////////
	// behaviors

	task automatic write_cfg_joy();
		int          r;
		int          j;
		word_t       w;
		logic [31:0] jv;
		for (r = 0; r < ROUNDS_CFG; r++) begin
			w = $random(seed);
			m_cfg = w;
			start_cmd(CMD_CFG);
			add_word(w);
			send_frame(1'b0, 0);
			for (j = 0; j < 4; j++) begin
				w = $random(seed);
				m_joy[j][15:0] = w;
				start_cmd(joy_code(j));
				add_word(w);
				// upper half only with a second word
				if ($random(seed) & 1) begin
					w = $random(seed);
					m_joy[j][31:16] = w;
					add_word(w);
				end
				send_frame(1'b0, 0);
			end
			check_word({5'd0, direct_video, 5'd0, forced_scandoubler, 2'd0, buttons},
				m_cfg & 16'h0413, "config outputs");
			for (j = 0; j < 4; j++) begin
				jv = joy_out(j);
				check_word(jv[15:0], m_joy[j][15:0], $sformatf("joystick_%0d low", j));
				check_word(jv[31:16], m_joy[j][31:16], $sformatf("joystick_%0d high", j));
			end
		end
	endtask

	task automatic read_status();
		int    r;
		int    k;
		int    n;
		word_t w;
		for (r = 0; r < ROUNDS_STATUS; r++) begin
			start_cmd(CMD_STATUS);
			for (k = 0; k < 4; k++) begin
				w = $random(seed);
				m_status[16*k +: 16] = w;
				add_word(w);
			end
			send_frame(1'b0, 0);
			for (k = 0; k < 4; k++) begin
				check_word(status[16*k +: 16], m_status[16*k +: 16], "status word");
			end

			n = 1 + ($random(seed) & 1);
			repeat (n) begin
				@(negedge clk_sys);
				status_in  = {$random(seed), $random(seed)};
				status_set = 1'b1;
				m_req      = status_in;
				m_stflg    = m_stflg + 1'b1;
				@(negedge clk_sys);
				status_set = 1'b0;
			end
			// later changes without a set edge are not captured
			status_in = {$random(seed), $random(seed)};

			start_cmd(CMD_STATUS_REQ);
			repeat (4) add_word($random(seed));
			send_frame(1'b0, 0);
			check_word(rx_words[0], {8'h00, STATUS_REQ_TAG, m_stflg}, "status request tag");
			for (k = 1; k <= 4; k++) begin
				check_word(rx_words[k], m_req[16*(k-1) +: 16], "requested status");
			end

			status_menumask = $random(seed);
			start_cmd(CMD_MENUMASK);
			add_word($random(seed));
			send_frame(1'b0, 0);
			check_word(rx_words[0], 16'h0000, "menu mask command reply");
			check_word(rx_words[1], status_menumask, "menu mask");

			raw_joy = $random(seed);
			start_cmd(CMD_RAWJOY);
			add_word($random(seed));
			send_frame(1'b0, 0);
			check_word(rx_words[1], {10'd0, raw_joy}, "raw joystick");
		end
	endtask

	task automatic read_confstr();
		int    k;
		word_t exp;
		start_cmd(CMD_CONFSTR);
		repeat (STRLEN + 2) add_word($random(seed));
		send_frame(1'b0, 0);
		check_word(rx_words[0], 16'h0000, "config string command reply");
		for (k = 1; k <= STRLEN + 2; k++) begin
			exp = (k <= STRLEN) ? {8'h00, conf_text.getc(k - 1)} : 16'h0000;
			check_word(rx_words[k], exp, $sformatf("config string word %0d", k));
		end
	endtask

	task automatic send_key_frame(input logic [9:0] ev, input string what);
		send_frame(1'b0, 0);
		m_key.toggle = ~m_key.toggle;
		{m_key.pressed, m_key.extended, m_key.code} = ev;
		check_key(ps2_key, m_key, what);
	endtask

	task automatic type_keys();
		int         i;
		logic [7:0] code;
		logic       pr;
		logic       ex;
		for (i = 0; i < KEY_ITER; i++) begin
			code = $random(seed);
			pr   = $random(seed);
			ex   = $random(seed);
			start_cmd(CMD_KBD);
			if (ex) add_word(16'h00e0);
			if (!pr) add_word(16'h00f0);
			add_word({8'h00, code});
			send_key_frame({pr, ex, code}, "random key");
		end

		start_cmd(CMD_KBD);
		add_word(16'h00e0);
		add_word(16'h0012);
		add_word(16'h00e0);
		add_word(16'h007c);
		send_key_frame(10'h37c, "print screen make");

		start_cmd(CMD_KBD);
		add_word(16'h007c);
		add_word(16'h00e0);
		add_word(16'h00f0);
		add_word(16'h0012);
		send_key_frame(10'h17c, "print screen break");

		start_cmd(CMD_KBD);
		add_word(16'h00f0);
		add_word(16'h0014);
		add_word(16'h00f0);
		add_word(16'h0077);
		send_key_frame(10'h377, "pause");

		// a word with high byte ff drops the whole frame
		start_cmd(CMD_KBD);
		add_word(16'h001c);
		add_word({8'hff, 8'h5a});
		add_word(16'h0032);
		send_frame(1'b0, 0);
		check_key(ps2_key, m_key, "skipped frame");
	endtask

	task automatic download_file();
		int                   i;
		word_t                w;
		word_t                idx;
		logic [31:0]          ext;
		logic [DL_ADDR_W-1:0] start;
		idx = $random(seed);
		start_cmd(FIO_FILE_INDEX);
		add_word(idx);
		send_frame(1'b1, 0);
		check_word(ioctl_index, idx, "file index");

		ext = $random(seed);
		start_cmd(FIO_FILE_INFO);
		add_word(ext[31:16]);
		add_word(ext[15:0]);
		send_frame(1'b1, 0);
		check_word(ioctl_file_ext[31:16], ext[31:16], "extension high");
		check_word(ioctl_file_ext[15:0], ext[15:0], "extension low");

		start = $random(seed);
		start_cmd(FIO_FILE_TX);
		add_word(16'h0001 | word_t'($random(seed)));
		add_word(start[15:0]);
		add_word({5'd0, start[26:16]});
		send_frame(1'b1, 0);
		check_word({15'd0, ioctl_download}, 16'h0001, "download start");

		// one idle cycle between bytes keeps each write aligned with its data
		start_cmd(FIO_FILE_TX_DAT);
		for (i = 0; i < DL_BYTES; i++) begin
			w = $random(seed);
			add_word(w);
			dl_addr_q.push_back(DL_ADDR_W'(start + i));
			dl_data_q.push_back(w[7:0]);
		end
		send_frame(1'b1, 1);
		if (dl_addr_q.size() != 0) begin
			abort_run($sformatf("download ended with %0d bytes never written",
				dl_addr_q.size()));
		end

		start_cmd(FIO_FILE_TX);
		add_word(16'h0000);
		send_frame(1'b1, 0);
		check_word({15'd0, ioctl_download}, 16'h0000, "download stop");

		// no writes expected from here on
		start_cmd(FIO_FILE_TX_DAT);
		repeat (3) add_word($random(seed));
		send_frame(1'b1, 1);
		check_word(fp_dout, 16'h0000, "fp_dout");
	endtask

	////////////////////
	// main sequence

	initial begin
		int k;
		seed            = 11083;
		cycle_count     = 0;
		conf_text       = "ARCADE";
		rst_n           = 1'b0;
		io_enable       = 1'b0;
		fp_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		raw_joy         = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		m_cfg           = '0;
		m_joy           = '{default: '0};
		m_status        = '0;
		m_stflg         = '0;
		m_req           = '0;
		m_key           = '0;
		// first character in the top byte
		for (k = 0; k < STRLEN; k++) begin
			conf_str[8*(STRLEN-1-k) +: 8] = conf_text.getc(k);
		end

		repeat (RESET_CYCLES) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		check_word(io_dout, 16'h0000, "io_dout after reset");
		check_key(ps2_key, m_key, "after reset");
		check_word({14'd0, ioctl_download, ioctl_wr}, 16'h0000, "download port after reset");

		write_cfg_joy();
		read_status();
		read_confstr();
		type_keys();
		download_file();

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
hps_pkg.sv
hps_cmd_if.sv
hps_cmd_frame.sv
hps_user_regs.sv
hps_ps2_key.sv
hps_file_rx.sv
hps_io.sv
hps_io_assert.sv
tb_hps_io.sv
